// ==== hdl/chrono_pkg.sv ====
// ################################################
// time field types, field limits and key indices
// shared by the front panel and the two counters
// refer to items as chrono_pkg::name
// ################################################
package chrono_pkg;

    typedef logic [5:0]  hour_t;
    typedef logic [5:0]  minute_t;  // seconds use it too
    typedef logic [6:0]  centi_t;
    typedef logic [19:0] key_t;

    localparam hour_t   max_hour   = 6'd23;
    localparam minute_t max_minute = 6'd59;
    localparam centi_t  max_centi  = 7'd99;

    // key positions on pb
    localparam int key_view_timer     = 0;
    localparam int key_view_stopwatch = 1;
    localparam int key_dec            = 4;
    localparam int key_inc            = 5;
    localparam int key_step           = 6;
    localparam int key_start          = 7;

    typedef enum logic {
        view_timer,
        view_stopwatch
    } view_t;

    typedef enum logic [1:0] {
        set_hours,
        set_minutes,
        armed
    } timer_mode_t;

    // stopwatch never reaches expired
    typedef enum logic [1:0] {
        stopped,
        running,
        expired
    } run_t;

endpackage

// ==== hdl/display_pkg.sv ====
// ################################################
// digit and segment types for the 7-seg board
// plus the 0-9 segment table, segment a in bit 0
// refer to items as display_pkg::name
// ################################################
package display_pkg;

    typedef logic [3:0] bcd_t;
    typedef logic [6:0] seg_t;
    typedef logic [7:0] ss_t;  // dp in bit 7

    // gfedcba
    localparam seg_t digit_segments [0:9] = '{
        7'b0111111,  // 0
        7'b0000110,  // 1
        7'b1011011,  // 2
        7'b1001111,  // 3
        7'b1100110,  // 4
        7'b1101101,  // 5
        7'b1111101,  // 6
        7'b0000111,  // 7
        7'b1111111,  // 8
        7'b1100111   // 9
    };

    // unlit digit, kept for blanking
    localparam seg_t blank_segments = 7'b0000000;

    // position of the decimal point in ss_t
    localparam int dp_bit = 7;

    // digits on the board, ss7 leftmost
    localparam int num_digits = 8;

    // largest value a single bcd digit holds here
    localparam bcd_t max_digit = 4'd9;

endpackage

// ==== hdl/panel_if.sv ====
// ################################################
// tick and qualified key events, front panel to
// the counters; view goes on to the display
// ################################################
`timescale 1ns/100ps

interface panel_if;

    logic              tick;       // one cycle per centisecond
    chrono_pkg::view_t view;
    logic              tmr_inc;
    logic              tmr_dec;
    logic              tmr_step;
    logic              tmr_start;
    logic              sw_start;

    modport source (
        output tick, view, tmr_inc, tmr_dec, tmr_step, tmr_start, sw_start
    );

    modport sink (
        input tick, tmr_inc, tmr_dec, tmr_step, tmr_start, sw_start
    );

    modport display (input view);

endinterface

// ==== hdl/time_if.sv ====
// ################################################
// one hh:mm:ss.cc value from a counter to the
// display, valid every cycle
// ################################################
`timescale 1ns/100ps

interface time_if;

    chrono_pkg::hour_t   hours;
    chrono_pkg::minute_t minutes;
    chrono_pkg::minute_t seconds;
    chrono_pkg::centi_t  centis;

    modport source (
        output hours, minutes, seconds, centis
    );

    modport display (
        input hours, minutes, seconds, centis
    );

endinterface

// ==== hdl/front_panel.sv ====
// ################################################
// samples pb, turns a fresh press into one event
// for the highest key, holds the view and makes
// the centisecond tick every tick_div cycles
// ################################################
`timescale 1ns/100ps

module front_panel #(
    parameter int tick_div = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  chrono_pkg::key_t pb,
    panel_if.source          panel
);
    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    chrono_pkg::key_t pb_q;
    chrono_pkg::key_t pb_prev;
    logic [cnt_w-1:0] div_cnt;
    logic [4:0]       top_key;
    logic             press;
    logic             tmr_press;
    logic             sw_press;

    // all keys were up on the previous sample
    assign press     = (|pb_q) && !(|pb_prev);
    assign tmr_press = press && (panel.view == chrono_pkg::view_timer);
    assign sw_press  = press && (panel.view == chrono_pkg::view_stopwatch);

    always_comb begin
        top_key = 5'd0;
        for (int i = 0; i < $bits(chrono_pkg::key_t); i++) begin
            if (pb_q[i]) begin
                top_key = 5'(i);  // highest wins
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pb_q            <= '0;
            pb_prev         <= '0;
            panel.view      <= chrono_pkg::view_timer;
            panel.tmr_inc   <= 1'b0;
            panel.tmr_dec   <= 1'b0;
            panel.tmr_step  <= 1'b0;
            panel.tmr_start <= 1'b0;
            panel.sw_start  <= 1'b0;
        end else begin
            pb_q            <= pb;
            pb_prev         <= pb_q;
            panel.tmr_inc   <= tmr_press && (top_key == 5'(chrono_pkg::key_inc));
            panel.tmr_dec   <= tmr_press && (top_key == 5'(chrono_pkg::key_dec));
            panel.tmr_step  <= tmr_press && (top_key == 5'(chrono_pkg::key_step));
            panel.tmr_start <= tmr_press && (top_key == 5'(chrono_pkg::key_start));
            panel.sw_start  <= sw_press && (top_key == 5'(chrono_pkg::key_start));
            if (press && top_key == 5'(chrono_pkg::key_view_timer)) begin
                panel.view <= chrono_pkg::view_timer;
            end else if (press && top_key == 5'(chrono_pkg::key_view_stopwatch)) begin
                panel.view <= chrono_pkg::view_stopwatch;
            end
        end
    end

    // centisecond prescaler
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            div_cnt    <= '0;
            panel.tick <= 1'b0;
        end else if (div_cnt == cnt_w'(tick_div - 1)) begin
            div_cnt    <= '0;
            panel.tick <= 1'b1;
        end else begin
            div_cnt    <= div_cnt + 1'b1;
            panel.tick <= 1'b0;
        end
    end

endmodule

// ==== hdl/countdown_timer.sv ====
// ################################################
// settable countdown timer; step walks the set
// modes, start runs it from armed, done is raised
// at zero until step clears it
// ################################################
`timescale 1ns/100ps

module countdown_timer (
    input  logic   clk,
    input  logic   reset,
    panel_if.sink  panel,
    time_if.source tmr,
    output logic   done
);
    chrono_pkg::timer_mode_t mode, mode_n;
    chrono_pkg::run_t        run_state, run_n;
    chrono_pkg::hour_t       hours_n;
    chrono_pkg::minute_t     minutes_n, seconds_n;
    chrono_pkg::centi_t      centis_n;
    logic                    done_n;
    logic                    at_zero;

    assign at_zero = {tmr.hours, tmr.minutes, tmr.seconds, tmr.centis} == '0;

    always_comb begin
        mode_n    = mode;
        run_n     = run_state;
        done_n    = done;
        hours_n   = tmr.hours;
        minutes_n = tmr.minutes;
        seconds_n = tmr.seconds;
        centis_n  = tmr.centis;

        if (panel.tmr_step && run_state == chrono_pkg::expired) begin
            mode_n = chrono_pkg::set_hours;
            run_n  = chrono_pkg::stopped;
            done_n = 1'b0;
        end else if (panel.tmr_step && run_state == chrono_pkg::stopped) begin
            case (mode)
                chrono_pkg::set_hours:   mode_n = chrono_pkg::set_minutes;
                chrono_pkg::set_minutes: mode_n = chrono_pkg::armed;
                default:                 mode_n = chrono_pkg::set_hours;
            endcase
        end

        // field edit, wraps both ways
        if (run_state == chrono_pkg::stopped && mode == chrono_pkg::set_hours) begin
            if (panel.tmr_inc) begin
                hours_n = (tmr.hours == chrono_pkg::max_hour) ? '0 : tmr.hours + 6'd1;
            end else if (panel.tmr_dec) begin
                hours_n = (tmr.hours == '0) ? chrono_pkg::max_hour : tmr.hours - 6'd1;
            end
        end
        if (run_state == chrono_pkg::stopped && mode == chrono_pkg::set_minutes) begin
            if (panel.tmr_inc) begin
                minutes_n = (tmr.minutes == chrono_pkg::max_minute) ? '0 : tmr.minutes + 6'd1;
            end else if (panel.tmr_dec) begin
                minutes_n = (tmr.minutes == '0) ? chrono_pkg::max_minute : tmr.minutes - 6'd1;
            end
        end

        if (panel.tmr_start && mode == chrono_pkg::armed && run_state != chrono_pkg::expired) begin
            run_n = (run_state == chrono_pkg::running) ? chrono_pkg::stopped : chrono_pkg::running;
        end

        if (run_state == chrono_pkg::running && at_zero) begin
            run_n  = chrono_pkg::expired;
            done_n = 1'b1;
        end else if (run_state == chrono_pkg::running && panel.tick) begin
            centis_n = (tmr.centis == '0) ? chrono_pkg::max_centi : tmr.centis - 7'd1;
            if (tmr.centis == '0) begin
                seconds_n = (tmr.seconds == '0) ? chrono_pkg::max_minute : tmr.seconds - 6'd1;
                if (tmr.seconds == '0) begin
                    minutes_n = (tmr.minutes == '0) ? chrono_pkg::max_minute : tmr.minutes - 6'd1;
                    if (tmr.minutes == '0) begin
                        hours_n = tmr.hours - 6'd1;  // nonzero here
                    end
                end
            end
            if ({hours_n, minutes_n, seconds_n, centis_n} == '0) begin
                run_n  = chrono_pkg::expired;
                done_n = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            mode        <= chrono_pkg::set_hours;
            run_state   <= chrono_pkg::stopped;
            done        <= 1'b0;
            tmr.hours   <= '0;
            tmr.minutes <= '0;
            tmr.seconds <= '0;
            tmr.centis  <= '0;
        end else begin
            mode        <= mode_n;
            run_state   <= run_n;
            done        <= done_n;
            tmr.hours   <= hours_n;
            tmr.minutes <= minutes_n;
            tmr.seconds <= seconds_n;
            tmr.centis  <= centis_n;
        end
    end

endmodule

// ==== hdl/stopwatch.sv ====
// ################################################
// count-up stopwatch toggled by sw_start; counts
// one centisecond per tick, stops at 23:59:59.99
// ################################################
`timescale 1ns/100ps

module stopwatch (
    input  logic   clk,
    input  logic   reset,
    panel_if.sink  panel,
    time_if.source sw
);
    chrono_pkg::run_t run_state;
    logic             at_max;

    assign at_max = sw.hours == chrono_pkg::max_hour && sw.minutes == chrono_pkg::max_minute
                 && sw.seconds == chrono_pkg::max_minute && sw.centis == chrono_pkg::max_centi;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            run_state <= chrono_pkg::stopped;
        end else if (panel.sw_start) begin
            run_state <= (run_state == chrono_pkg::running) ? chrono_pkg::stopped
                                                            : chrono_pkg::running;
        end
    end

    // the edge that stops the watch still takes its tick
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sw.hours   <= '0;
            sw.minutes <= '0;
            sw.seconds <= '0;
            sw.centis  <= '0;
        end else if (run_state == chrono_pkg::running && panel.tick && !at_max) begin
            if (sw.centis != chrono_pkg::max_centi) begin
                sw.centis <= sw.centis + 7'd1;
            end else begin
                sw.centis <= '0;
                if (sw.seconds != chrono_pkg::max_minute) begin
                    sw.seconds <= sw.seconds + 6'd1;
                end else begin
                    sw.seconds <= '0;
                    if (sw.minutes != chrono_pkg::max_minute) begin
                        sw.minutes <= sw.minutes + 6'd1;
                    end else begin
                        sw.minutes <= '0;
                        sw.hours   <= sw.hours + 6'd1;  // below 23 here
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/segment_display.sv ====
// ################################################
// picks timer or stopwatch time by view, splits
// each field into two digits and registers the
// eight segment outputs and done
// ################################################
`timescale 1ns/100ps

module segment_display (
    input  logic             clk,
    input  logic             reset,
    panel_if.display         panel,
    time_if.display          tmr,
    time_if.display          sw,
    input  logic             tmr_done,
    output display_pkg::ss_t ss7,
    output display_pkg::ss_t ss6,
    output display_pkg::ss_t ss5,
    output display_pkg::ss_t ss4,
    output display_pkg::ss_t ss3,
    output display_pkg::ss_t ss2,
    output display_pkg::ss_t ss1,
    output display_pkg::ss_t ss0,
    output logic             done
);
    chrono_pkg::hour_t   hours;
    chrono_pkg::minute_t minutes;
    chrono_pkg::minute_t seconds;
    chrono_pkg::centi_t  centis;

    // tens digit then ones digit, dp only on the ones
    function automatic logic [15:0] digit_pair(input logic [6:0] value, input logic dp);
        display_pkg::bcd_t tens;
        display_pkg::bcd_t ones;
        tens = display_pkg::bcd_t'(value / 7'd10);
        ones = display_pkg::bcd_t'(value % 7'd10);
        return {1'b0, display_pkg::digit_segments[tens], dp, display_pkg::digit_segments[ones]};
    endfunction

    always_comb begin
        if (panel.view == chrono_pkg::view_stopwatch) begin
            hours   = sw.hours;
            minutes = sw.minutes;
            seconds = sw.seconds;
            centis  = sw.centis;
        end else begin
            hours   = tmr.hours;
            minutes = tmr.minutes;
            seconds = tmr.seconds;
            centis  = tmr.centis;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            {ss7, ss6} <= digit_pair(7'd0, 1'b1);
            {ss5, ss4} <= digit_pair(7'd0, 1'b1);
            {ss3, ss2} <= digit_pair(7'd0, 1'b1);
            {ss1, ss0} <= digit_pair(7'd0, 1'b0);
            done       <= 1'b0;
        end else begin
            {ss7, ss6} <= digit_pair({1'b0, hours}, 1'b1);
            {ss5, ss4} <= digit_pair({1'b0, minutes}, 1'b1);
            {ss3, ss2} <= digit_pair({1'b0, seconds}, 1'b1);
            {ss1, ss0} <= digit_pair(centis, 1'b0);
            done       <= tmr_done;  // lines up with ss
        end
    end

endmodule

// ==== hdl/chrono_top.sv ====
// ################################################
// chronometer top: front panel, countdown timer,
// stopwatch and display wired by interfaces
// tick_div sets clk cycles per centisecond
// ################################################
`timescale 1ns/100ps

module chrono_top #(
    parameter int tick_div = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [19:0] pb,
    output logic [7:0]  ss7,
    output logic [7:0]  ss6,
    output logic [7:0]  ss5,
    output logic [7:0]  ss4,
    output logic [7:0]  ss3,
    output logic [7:0]  ss2,
    output logic [7:0]  ss1,
    output logic [7:0]  ss0,
    output logic        done
);
    panel_if panel ();
    time_if  tmr_time ();
    time_if  sw_time ();
    logic    tmr_done;

    front_panel #(
        .tick_div (tick_div)
    ) u_front_panel (
        .clk   (clk),
        .reset (reset),
        .pb    (pb),
        .panel (panel.source)
    );

    countdown_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .panel (panel.sink),
        .tmr   (tmr_time.source),
        .done  (tmr_done)
    );

    stopwatch u_stopwatch (
        .clk   (clk),
        .reset (reset),
        .panel (panel.sink),
        .sw    (sw_time.source)
    );

    segment_display u_display (
        .clk      (clk),
        .reset    (reset),
        .panel    (panel.display),
        .tmr      (tmr_time.display),
        .sw       (sw_time.display),
        .tmr_done (tmr_done),
        .ss7      (ss7),
        .ss6      (ss6),
        .ss5      (ss5),
        .ss4      (ss4),
        .ss3      (ss3),
        .ss2      (ss2),
        .ss1      (ss1),
        .ss0      (ss0),
        .done     (done)
    );

endmodule

// ==== test/chrono_asserts.sv ====
// ################################################
// concurrent checks on the countdown timer, bound
// into every countdown_timer instance
// ################################################
`timescale 1ns/100ps

module chrono_asserts (
    input logic                clk,
    input logic                reset,
    input chrono_pkg::run_t    run_state,
    input logic                done,
    input chrono_pkg::hour_t   hours,
    input chrono_pkg::minute_t minutes,
    input chrono_pkg::minute_t seconds,
    input chrono_pkg::centi_t  centis,
    input logic                tmr_inc,
    input logic                tmr_dec,
    input logic                tmr_step,
    input logic                tmr_start,
    input logic                sw_start
);
    int fail_count = 0;

    fields_in_range: assert property (@(posedge clk) disable iff (reset)
        hours <= chrono_pkg::max_hour && minutes <= chrono_pkg::max_minute
        && seconds <= chrono_pkg::max_minute && centis <= chrono_pkg::max_centi)
        else begin
            $error("timer field beyond its limit");
            fail_count = fail_count + 1;
        end

    // done tracks the expired state exactly
    done_is_expired: assert property (@(posedge clk) disable iff (reset)
        done == (run_state == chrono_pkg::expired))
        else begin
            $error("done differs from expired state");
            fail_count = fail_count + 1;
        end

    one_event: assert property (@(posedge clk) disable iff (reset)
        $onehot0({tmr_inc, tmr_dec, tmr_step, tmr_start, sw_start}))
        else begin
            $error("more than one panel event in a cycle");
            fail_count = fail_count + 1;
        end

endmodule

bind countdown_timer chrono_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .run_state (run_state),
    .done      (done),
    .hours     (tmr.hours),
    .minutes   (tmr.minutes),
    .seconds   (tmr.seconds),
    .centis    (tmr.centis),
    .tmr_inc   (panel.tmr_inc),
    .tmr_dec   (panel.tmr_dec),
    .tmr_step  (panel.tmr_step),
    .tmr_start (panel.tmr_start),
    .sw_start  (panel.sw_start)
);

// ==== test/chrono_tb.sv ====
// ################################################
// testbench for chrono_top: walks a table of key
// presses and waits, then checks all eight digits
// and done against values worked out per row
// ################################################
`timescale 1ns/100ps

module chrono_tb;

    localparam int key_none  = -1;
    localparam int reset_len = 4;

    typedef struct packed {
        int key;
        int wait_cycles;  // edges after the press edge
        int hh;
        int mm;
        int sec;
        int cc;
        bit done;
    } row_t;

    logic             clk;
    logic             reset;
    chrono_pkg::key_t pb;
    logic [7:0]       ss7;
    logic [7:0]       ss6;
    logic [7:0]       ss5;
    logic [7:0]       ss4;
    logic [7:0]       ss3;
    logic [7:0]       ss2;
    logic [7:0]       ss1;
    logic [7:0]       ss0;
    logic             done;

    row_t rows[$];
    int   cycle_count = 0;
    int   cycle_limit = 0;

    chrono_top #(
        .tick_div (1)
    ) u_dut (
        .clk   (clk),
        .reset (reset),
        .pb    (pb),
        .ss7   (ss7),
        .ss6   (ss6),
        .ss5   (ss5),
        .ss4   (ss4),
        .ss3   (ss3),
        .ss2   (ss2),
        .ss1   (ss1),
        .ss0   (ss0),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input int key, input int wait_cycles, input int hh, input int mm,
                           input int sec, input int cc, input bit done_exp);
        row_t r;
        r.key         = key;
        r.wait_cycles = wait_cycles;
        r.hh          = hh;
        r.mm          = mm;
        r.sec         = sec;
        r.cc          = cc;
        r.done        = done_exp;
        rows.push_back(r);
    endtask

    // key, wait, hh, mm, ss, cc, done
    task automatic load_table();
        add_row(key_none, 4, 0, 0, 0, 0, 1'b0);
        add_row(chrono_pkg::key_dec, 4, 23, 0, 0, 0, 1'b0);    // hours wrap down
        add_row(chrono_pkg::key_inc, 4, 0, 0, 0, 0, 1'b0);
        add_row(chrono_pkg::key_step, 4, 0, 0, 0, 0, 1'b0);    // set_minutes
        add_row(chrono_pkg::key_inc, 4, 0, 1, 0, 0, 1'b0);
        add_row(chrono_pkg::key_inc, 4, 0, 2, 0, 0, 1'b0);
        add_row(chrono_pkg::key_step, 4, 0, 2, 0, 0, 1'b0);    // armed
        add_row(chrono_pkg::key_inc, 4, 0, 2, 0, 0, 1'b0);     // ignored when armed
        add_row(chrono_pkg::key_step, 4, 0, 2, 0, 0, 1'b0);
        add_row(chrono_pkg::key_step, 4, 0, 2, 0, 0, 1'b0);
        add_row(chrono_pkg::key_dec, 4, 0, 1, 0, 0, 1'b0);
        add_row(chrono_pkg::key_step, 4, 0, 1, 0, 0, 1'b0);
        // one minute at one tick per cycle, zero after 6003 edges
        add_row(chrono_pkg::key_start, 6010, 0, 0, 0, 0, 1'b1);
        add_row(chrono_pkg::key_inc, 4, 0, 0, 0, 0, 1'b1);
        add_row(chrono_pkg::key_step, 4, 0, 0, 0, 0, 1'b0);    // clears expiry
        add_row(chrono_pkg::key_inc, 4, 1, 0, 0, 0, 1'b0);
        add_row(chrono_pkg::key_view_stopwatch, 4, 0, 0, 0, 0, 1'b0);
        // counts from press+4, display lags one edge
        add_row(chrono_pkg::key_start, 250, 0, 0, 2, 46, 1'b0);
        add_row(chrono_pkg::key_start, 4, 0, 0, 2, 51, 1'b0);  // 251 edges between presses
        add_row(key_none, 20, 0, 0, 2, 51, 1'b0);
        add_row(chrono_pkg::key_inc, 4, 0, 0, 2, 51, 1'b0);
        add_row(chrono_pkg::key_dec, 4, 0, 0, 2, 51, 1'b0);
        add_row(chrono_pkg::key_dec, 4, 0, 0, 2, 51, 1'b0);
        add_row(chrono_pkg::key_step, 4, 0, 0, 2, 51, 1'b0);
        add_row(chrono_pkg::key_view_timer, 4, 1, 0, 0, 0, 1'b0);
        add_row(chrono_pkg::key_inc, 4, 2, 0, 0, 0, 1'b0);     // still in set_hours
        add_row(chrono_pkg::key_view_stopwatch, 4, 0, 0, 2, 51, 1'b0);
    endtask

    function automatic logic [7:0] digit_pattern(input int value, input bit dp);
        return {dp, display_pkg::digit_segments[value]};
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_row(input int idx, input row_t r);
        string tag;
        tag = $sformatf("row %0d", idx);
        compare(32'(ss7), 32'(digit_pattern(r.hh / 10, 1'b0)), {tag, " ss7"});
        compare(32'(ss6), 32'(digit_pattern(r.hh % 10, 1'b1)), {tag, " ss6"});
        compare(32'(ss5), 32'(digit_pattern(r.mm / 10, 1'b0)), {tag, " ss5"});
        compare(32'(ss4), 32'(digit_pattern(r.mm % 10, 1'b1)), {tag, " ss4"});
        compare(32'(ss3), 32'(digit_pattern(r.sec / 10, 1'b0)), {tag, " ss3"});
        compare(32'(ss2), 32'(digit_pattern(r.sec % 10, 1'b1)), {tag, " ss2"});
        compare(32'(ss1), 32'(digit_pattern(r.cc / 10, 1'b0)), {tag, " ss1"});
        compare(32'(ss0), 32'(digit_pattern(r.cc % 10, 1'b0)), {tag, " ss0"});
        compare(32'(done), 32'(r.done), {tag, " done"});
    endtask

    // one-cycle press, then sample at the falling edge
    task automatic apply_row(input int idx, input row_t r);
        @(posedge clk);
        if (r.key != key_none) begin
            pb <= 20'd1 << r.key;
        end
        @(posedge clk);
        pb <= '0;
        repeat (r.wait_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_row(idx, r);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run ended by the cycle limit");
        end
    end

    initial begin
        int total;
        reset = 1'b1;
        pb    = '0;
        load_table();
        total = reset_len;
        foreach (rows[i]) begin
            total += rows[i].wait_cycles + 1;
        end
        cycle_limit = total + 100;
        repeat (reset_len) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            apply_row(i, rows[i]);
        end
        @(posedge clk);
        if (u_dut.u_timer.u_asserts.fail_count != 0) begin
            $display("timer assertions failed %0d times",
                     u_dut.u_timer.u_asserts.fail_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failures seen");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
hdl/chrono_pkg.sv
hdl/display_pkg.sv
hdl/panel_if.sv
hdl/time_if.sv
hdl/front_panel.sv
hdl/countdown_timer.sv
hdl/stopwatch.sv
hdl/segment_display.sv
hdl/chrono_top.sv
test/chrono_asserts.sv
test/chrono_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the chronometer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f compile.f --top-module chrono_tb -Mdir obj_dir

out=$(./obj_dir/Vchrono_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
